/* verilog.f */
design/bp_pkg.sv
design/btb.sv
design/agree_pht.sv
design/fetch_pc.sv
design/branch_front_end.sv
test/bp_checker.sv
test/tb_front_end.sv

/* test/tb_front_end.sv */
`timescale 1ns/100ps

module tb_front_end;

    localparam int HW = 8;
    localparam int RANDOM_RESOLUTIONS = 300;

    // What fetch showed for one instruction, echoed back at resolution
    typedef struct packed {
        logic [31:0]   pc;
        logic          hit;
        logic          pred;
        logic          bias;
        logic [HW-1:0] ghr;
    } fetch_rec_t;

    logic clk_i = 1'b0;
    logic rst_ni, stall_i, res_valid_i, res_is_branch_i, res_is_jump_i, res_taken_i;
    logic res_btb_hit_i, res_pred_taken_i, res_bias_i;
    logic [31:0] res_pc_i, res_target_i, pred_target_o;
    logic [HW-1:0] res_ghr_i, ghr_o;
    bp_pkg::pc_addr_u fetch_pc_o;
    logic btb_hit_o, pred_taken_o, bias_o, flush_o;
    int mismatch_count;
    int tests_passed = 0;
    int tests_failed = 0;
    int errors_before = 0;
    logic [31:0] rng_state = 32'd53;
    fetch_rec_t fq[$];

    always #2 clk_i = ~clk_i;

    branch_front_end #(.HISTORY_WIDTH(HW)) dut0 (.*);

    bp_checker #(.HISTORY_WIDTH(HW)) bp_checker (
        .fetch_pc_i(fetch_pc_o), .btb_hit_i(btb_hit_o), .pred_taken_i(pred_taken_o),
        .pred_target_i(pred_target_o), .bias_i(bias_o), .ghr_i(ghr_o), .flush_i(flush_o),
        .mismatch_count_o(mismatch_count), .*
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_cycle();
        @(posedge clk_i);
        #0.5;
    endtask

    task automatic resolve(input logic [31:0] pc, input logic br, input logic jp,
                           input logic tk, input logic [31:0] tgt, input logic hit,
                           input logic pred, input logic bias, input logic [HW-1:0] ghr);
        res_valid_i      = 1'b1;
        res_pc_i         = pc;
        res_is_branch_i  = br;
        res_is_jump_i    = jp;
        res_taken_i      = tk;
        res_target_i     = tgt;
        res_btb_hit_i    = hit;
        res_pred_taken_i = pred;
        res_bias_i       = bias;
        res_ghr_i        = ghr;
        next_cycle();
        res_valid_i = 1'b0;
    endtask

    // Resolve the instruction now at fetch with the metadata fetch shows for it
    task automatic resolve_fetched(input logic br, input logic jp, input logic tk,
                                   input logic [31:0] tgt);
        resolve(fetch_pc_o.raw, br, jp, tk, tgt, btb_hit_o, pred_taken_o,
                btb_hit_o ? bias_o : tk, ghr_o);
    endtask

    // Non-control instruction resolved taken, steers fetch without touching the tables
    task automatic redirect_to(input logic [31:0] addr);
        resolve(32'h0, 1'b0, 1'b0, 1'b1, addr, 1'b0, 1'b0, 1'b0, '0);
    endtask

    task automatic wait_for_pc(input logic [31:0] addr, input int limit);
        int n;
        n = 0;
        while (fetch_pc_o.raw !== addr && n < limit) begin
            next_cycle();
            n++;
        end
        if (fetch_pc_o.raw !== addr) begin
            $display("Timeout: fetch PC did not reach %h within %0d cycles", addr, limit);
            $display("** FAIL **");
            $finish;
        end
    endtask

    task automatic end_test(input string name);
        if (mismatch_count == errors_before) begin
            tests_passed++;
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed, %0d mismatches", name, mismatch_count - errors_before);
        end
        errors_before = mismatch_count;
    endtask

    // Instruction kind and target follow from the PC, only the branch outcome is random
    task automatic random_stream();
        fetch_rec_t  rec;
        logic [31:0] r;
        logic        jp, tk;
        int          n_res, cycles;
        n_res  = 0;
        cycles = 0;
        while (n_res < RANDOM_RESOLUTIONS && cycles < 4000) begin
            rng_state = xorshift(rng_state);
            r = rng_state;
            stall_i = (r[2:0] == 3'd0);
            if (fq.size() > 0 && (r[5:4] != 2'b00 || fq.size() > 6)) begin
                rec = fq.pop_front();
                jp  = (rec.pc[5:4] == 2'b10);
                tk  = jp || (rec.pc[4] && r[8]);
                res_valid_i      = 1'b1;
                res_pc_i         = rec.pc;
                res_is_branch_i  = rec.pc[4];
                res_is_jump_i    = jp;
                res_taken_i      = tk;
                res_target_i     = (rec.pc ^ 32'h150) & 32'hffc;
                res_btb_hit_i    = rec.hit;
                res_pred_taken_i = rec.pred;
                res_bias_i       = rec.hit ? rec.bias : tk;
                res_ghr_i        = rec.ghr;
                n_res++;
            end
            @(negedge clk_i);
            if (flush_o) begin
                fq.delete();
            end else if (!stall_i) begin
                fq.push_back({fetch_pc_o.raw, btb_hit_o, pred_taken_o, bias_o, ghr_o});
            end
            next_cycle();
            res_valid_i = 1'b0;
            cycles++;
        end
        stall_i = 1'b0;
        if (n_res < RANDOM_RESOLUTIONS) begin
            $display("Timeout: only %0d resolutions issued in the random stream", n_res);
            $display("** FAIL **");
            $finish;
        end
    endtask

    initial begin
        int tries;
        rst_ni = 1'b0;
        stall_i = 1'b0;
        resolve_idle: begin
            res_valid_i = 1'b0;
            res_pc_i = '0;
            res_is_branch_i = 1'b0;
            res_is_jump_i = 1'b0;
            res_taken_i = 1'b0;
            res_target_i = '0;
            res_btb_hit_i = 1'b0;
            res_pred_taken_i = 1'b0;
            res_bias_i = 1'b0;
            res_ghr_i = '0;
        end
        repeat (10) @(posedge clk_i);
        #0.5;
        rst_ni = 1'b1;

        wait_for_pc(32'h20, 12);
        end_test("reset and sequential fetch");

        stall_i = 1'b1;
        repeat (6) next_cycle();
        stall_i = 1'b0;
        next_cycle();
        end_test("stall");

        resolve(32'h40, 1'b0, 1'b1, 1'b1, 32'h200, 1'b0, 1'b0, 1'b1, ghr_o);
        wait_for_pc(32'h200, 2);
        redirect_to(32'h40);
        wait_for_pc(32'h40, 2);
        wait_for_pc(32'h200, 2);
        end_test("jump allocation");

        // Allocate with bias taken, then train not-taken until the prediction flips
        redirect_to(32'h80);
        wait_for_pc(32'h80, 2);
        resolve_fetched(1'b1, 1'b0, 1'b1, 32'h300);
        wait_for_pc(32'h300, 2);
        redirect_to(32'h80);
        wait_for_pc(32'h80, 2);
        tries = 0;
        while (pred_taken_o && tries < 16) begin
            resolve_fetched(1'b1, 1'b0, 1'b0, 32'h300);
            wait_for_pc(32'h84, 2);
            redirect_to(32'h80);
            wait_for_pc(32'h80, 2);
            tries++;
        end
        if (pred_taken_o) begin
            $display("Timeout: prediction at 80 still taken after %0d resolutions", tries);
            $display("** FAIL **");
            $finish;
        end
        next_cycle();
        end_test("agree training");

        random_stream();
        end_test("random stream");

        $display("Tests passed: %0d, failed: %0d, mismatches: %0d",
                 tests_passed, tests_failed, mismatch_count);
        if (tests_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* test/bp_checker.sv */
`timescale 1ns/100ps

module bp_checker #(
    parameter int HISTORY_WIDTH = 8
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     stall_i,
    input  bp_pkg::pc_addr_u         fetch_pc_i,
    input  logic                     btb_hit_i,
    input  logic                     pred_taken_i,
    input  logic [bp_pkg::XLEN-1:0]  pred_target_i,
    input  logic                     bias_i,
    input  logic [HISTORY_WIDTH-1:0] ghr_i,
    input  logic                     flush_i,
    input  logic                     res_valid_i,
    input  logic [bp_pkg::XLEN-1:0]  res_pc_i,
    input  logic                     res_is_branch_i,
    input  logic                     res_is_jump_i,
    input  logic                     res_taken_i,
    input  logic [bp_pkg::XLEN-1:0]  res_target_i,
    input  logic                     res_btb_hit_i,
    input  logic                     res_pred_taken_i,
    input  logic                     res_bias_i,
    input  logic [HISTORY_WIDTH-1:0] res_ghr_i,
    output int                       mismatch_count_o
);

    localparam int BTB_DEPTH = 1 << bp_pkg::INDEX_WIDTH;
    localparam int PHT_DEPTH = 1 << HISTORY_WIDTH;

    // Shadow copy of the predictor state
    logic                         m_valid  [BTB_DEPTH];
    logic [bp_pkg::TAG_WIDTH-1:0] m_tag    [BTB_DEPTH];
    logic [bp_pkg::XLEN-1:0]      m_target [BTB_DEPTH];
    logic                         m_bias   [BTB_DEPTH];
    logic                         m_jump   [BTB_DEPTH];
    logic [1:0]                   m_ctr    [PHT_DEPTH];
    logic [HISTORY_WIDTH-1:0]     m_ghr;
    bp_pkg::pc_addr_u             m_pc;
    bp_pkg::pc_addr_u             wr_addr;
    logic [HISTORY_WIDTH-1:0]     wr_idx;
    logic                         e_hit, e_taken, e_bias, e_flush;
    logic [bp_pkg::XLEN-1:0]      e_target, e_next;
    int                           errors = 0;

    // Expected fetch outputs and next PC for the current model state and inputs
    function automatic void compute_expected();
        logic [HISTORY_WIDTH-1:0] idx;
        logic                     agree;
        idx      = m_pc.raw[2 +: HISTORY_WIDTH] ^ m_ghr;
        agree    = (m_ctr[idx] >= 2'd2);
        e_hit    = m_valid[m_pc.f.index] && (m_tag[m_pc.f.index] == m_pc.f.tag);
        e_bias   = m_bias[m_pc.f.index];
        e_target = m_target[m_pc.f.index];
        e_taken  = e_hit && (m_jump[m_pc.f.index] || (agree ? e_bias : !e_bias));
        e_flush  = res_valid_i &&
                   (res_taken_i ? (!res_pred_taken_i || !res_btb_hit_i) : res_pred_taken_i);
        e_next   = e_flush ? (res_taken_i ? res_target_i : res_pc_i + 32'd4) :
                   stall_i ? m_pc.raw :
                   e_taken ? e_target : m_pc.raw + 32'd4;
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Outputs settle after the mid-cycle drive, compare on the falling edge
    always @(negedge clk_i) begin
        if (rst_ni) begin
            compute_expected();
            check("fetch_pc_o", fetch_pc_i.raw, m_pc.raw);
            check("btb_hit_o", btb_hit_i, e_hit);
            check("pred_taken_o", pred_taken_i, e_taken);
            check("flush_o", flush_i, e_flush);
            check("ghr_o", 32'(ghr_i), 32'(m_ghr));
            if (e_hit) begin
                check("pred_target_o", pred_target_i, e_target);
                check("bias_o", bias_i, e_bias);
            end
        end
    end

    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < BTB_DEPTH; i++) begin
                m_valid[i] = 1'b0;
            end
            for (int i = 0; i < PHT_DEPTH; i++) begin
                m_ctr[i] = bp_pkg::CTR_WEAK_AGREE;
            end
            m_ghr    = '0;
            m_pc.raw = bp_pkg::RESET_PC;
        end else begin
            compute_expected();
            wr_addr.raw = res_pc_i;
            wr_idx      = res_pc_i[2 +: HISTORY_WIDTH] ^ res_ghr_i;
            if (res_valid_i && (res_is_branch_i || res_is_jump_i)) begin
                m_valid[wr_addr.f.index]  = 1'b1;
                m_tag[wr_addr.f.index]    = wr_addr.f.tag;
                m_target[wr_addr.f.index] = res_target_i;
                m_jump[wr_addr.f.index]   = res_is_jump_i;
                if (!res_btb_hit_i) begin
                    m_bias[wr_addr.f.index] = res_taken_i;
                end
            end
            if (res_valid_i && res_is_branch_i) begin
                // Saturating move toward agree or disagree
                if (res_taken_i == res_bias_i) begin
                    m_ctr[wr_idx] = (m_ctr[wr_idx] == 2'd3) ? 2'd3 : m_ctr[wr_idx] + 2'd1;
                end else begin
                    m_ctr[wr_idx] = (m_ctr[wr_idx] == 2'd0) ? 2'd0 : m_ctr[wr_idx] - 2'd1;
                end
                m_ghr = {m_ghr[HISTORY_WIDTH-2:0], res_taken_i};
            end
            m_pc.raw = e_next;
        end
    end

    assign mismatch_count_o = errors;

endmodule

/* design/branch_front_end.sv */
`timescale 1ns/100ps

module branch_front_end #(
    parameter int HISTORY_WIDTH = 8
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     stall_i,

    // Fetch side
    output bp_pkg::pc_addr_u         fetch_pc_o,
    output logic                     btb_hit_o,
    output logic                     pred_taken_o,
    output logic [bp_pkg::XLEN-1:0]  pred_target_o,
    output logic                     bias_o,
    output logic [HISTORY_WIDTH-1:0] ghr_o,
    output logic                     flush_o,

    // Resolution side
    input  logic                     res_valid_i,
    input  logic [bp_pkg::XLEN-1:0]  res_pc_i,
    input  logic                     res_is_branch_i,
    input  logic                     res_is_jump_i,
    input  logic                     res_taken_i,
    input  logic [bp_pkg::XLEN-1:0]  res_target_i,
    input  logic                     res_btb_hit_i,
    input  logic                     res_pred_taken_i,
    input  logic                     res_bias_i,
    input  logic [HISTORY_WIDTH-1:0] res_ghr_i
);

    logic                    btb_is_jump;
    logic [bp_pkg::XLEN-1:0] btb_target;
    logic                    pht_agree;

    btb u_btb (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .rd_pc_i        (fetch_pc_o),
        .wr_en_i        (res_valid_i),
        .wr_pc_i        (res_pc_i),
        .wr_is_branch_i (res_is_branch_i),
        .wr_is_jump_i   (res_is_jump_i),
        .wr_taken_i     (res_taken_i),
        .wr_target_i    (res_target_i),
        .wr_hit_i       (res_btb_hit_i),
        .hit_o          (btb_hit_o),
        .is_jump_o      (btb_is_jump),
        .target_o       (btb_target),
        .bias_o         (bias_o)
    );

    agree_pht #(
        .HISTORY_WIDTH (HISTORY_WIDTH)
    ) u_agree_pht (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .rd_pc_i         (fetch_pc_o.raw),
        .upd_valid_i     (res_valid_i),
        .upd_is_branch_i (res_is_branch_i),
        .upd_pc_i        (res_pc_i),
        .upd_taken_i     (res_taken_i),
        .upd_bias_i      (res_bias_i),
        .upd_ghr_i       (res_ghr_i),
        .agree_o         (pht_agree),
        .ghr_o           (ghr_o)
    );

    fetch_pc u_fetch_pc (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .stall_i          (stall_i),
        .btb_hit_i        (btb_hit_o),
        .btb_is_jump_i    (btb_is_jump),
        .btb_target_i     (btb_target),
        .bias_i           (bias_o),
        .agree_i          (pht_agree),
        .res_valid_i      (res_valid_i),
        .res_pc_i         (res_pc_i),
        .res_taken_i      (res_taken_i),
        .res_target_i     (res_target_i),
        .res_btb_hit_i    (res_btb_hit_i),
        .res_pred_taken_i (res_pred_taken_i),
        .fetch_pc_o       (fetch_pc_o),
        .pred_taken_o     (pred_taken_o),
        .pred_target_o    (pred_target_o),
        .flush_o          (flush_o)
    );

endmodule

/* design/fetch_pc.sv */
`timescale 1ns/100ps

module fetch_pc (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    stall_i,

    // Lookup results for the current PC
    input  logic                    btb_hit_i,
    input  logic                    btb_is_jump_i,
    input  logic [bp_pkg::XLEN-1:0] btb_target_i,
    input  logic                    bias_i,
    input  logic                    agree_i,

    // Resolution from execute
    input  logic                    res_valid_i,
    input  logic [bp_pkg::XLEN-1:0] res_pc_i,
    input  logic                    res_taken_i,
    input  logic [bp_pkg::XLEN-1:0] res_target_i,
    input  logic                    res_btb_hit_i,
    input  logic                    res_pred_taken_i,

    output bp_pkg::pc_addr_u        fetch_pc_o,
    output logic                    pred_taken_o,
    output logic [bp_pkg::XLEN-1:0] pred_target_o,
    output logic                    flush_o
);

    localparam logic [bp_pkg::XLEN-1:0] PC_STEP = 4;

    bp_pkg::pc_addr_u        pc_q;
    logic [bp_pkg::XLEN-1:0] pc_plus4;
    logic [bp_pkg::XLEN-1:0] redirect_pc;
    logic [bp_pkg::XLEN-1:0] pc_next;

    // Jumps always taken, branches follow bias unless the PHT disagrees
    assign pred_taken_o  = btb_hit_i && (btb_is_jump_i || (agree_i ~^ bias_i));
    assign pred_target_o = btb_target_i;

    // Wrong direction, or taken without a BTB entry to supply the target
    assign flush_o = res_valid_i &&
                     ((res_taken_i != res_pred_taken_i) || (res_taken_i && !res_btb_hit_i));

    assign redirect_pc = res_taken_i ? res_target_i : (res_pc_i + PC_STEP);
    assign pc_plus4    = pc_q.raw + PC_STEP;

    always_comb begin
        if (flush_o) begin
            pc_next = redirect_pc;
        end else if (stall_i) begin
            pc_next = pc_q.raw;
        end else if (pred_taken_o) begin
            pc_next = btb_target_i;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pc_q.raw <= bp_pkg::RESET_PC;
        end else begin
            pc_q.raw <= pc_next;
        end
    end

    assign fetch_pc_o = pc_q;

    flush_inputs_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
        res_valid_i |-> !$isunknown({res_taken_i, res_pred_taken_i, res_btb_hit_i}));

    pc_word_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pc_q.f.offset == '0);

endmodule

/* design/agree_pht.sv */
`timescale 1ns/100ps

module agree_pht #(
    parameter int HISTORY_WIDTH = 8
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,

    // Prediction side
    input  logic [bp_pkg::XLEN-1:0]  rd_pc_i,

    // Training side, metadata echoed from fetch
    input  logic                     upd_valid_i,
    input  logic                     upd_is_branch_i,
    input  logic [bp_pkg::XLEN-1:0]  upd_pc_i,
    input  logic                     upd_taken_i,
    input  logic                     upd_bias_i,
    input  logic [HISTORY_WIDTH-1:0] upd_ghr_i,

    output logic                     agree_o,
    output logic [HISTORY_WIDTH-1:0] ghr_o
);

    localparam int PHT_DEPTH = 1 << HISTORY_WIDTH;

    logic [1:0]               ctr_q [PHT_DEPTH];
    logic [HISTORY_WIDTH-1:0] ghr_q;
    logic [HISTORY_WIDTH-1:0] rd_idx;
    logic [HISTORY_WIDTH-1:0] upd_idx;
    logic                     upd_fire;
    logic                     upd_agree;

    // Gshare-style index, word index bits folded with history
    assign rd_idx  = rd_pc_i[HISTORY_WIDTH+1:2] ^ ghr_q;
    assign upd_idx = upd_pc_i[HISTORY_WIDTH+1:2] ^ upd_ghr_i;

    // Jumps never train the counters
    assign upd_fire  = upd_valid_i && upd_is_branch_i;
    assign upd_agree = (upd_taken_i == upd_bias_i);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < PHT_DEPTH; i++) begin
                ctr_q[i] <= bp_pkg::CTR_WEAK_AGREE;
            end
        end else if (upd_fire) begin
            if (upd_agree && (ctr_q[upd_idx] != 2'b11)) begin
                ctr_q[upd_idx] <= ctr_q[upd_idx] + 2'b01;
            end else if (!upd_agree && (ctr_q[upd_idx] != 2'b00)) begin
                ctr_q[upd_idx] <= ctr_q[upd_idx] - 2'b01;
            end
        end
    end

    // History only moves on resolution, newest outcome in bit 0
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ghr_q <= '0;
        end else if (upd_fire) begin
            ghr_q <= (ghr_q << 1) | HISTORY_WIDTH'(upd_taken_i);
        end
    end

    assign agree_o = ctr_q[rd_idx][1];
    assign ghr_o   = ghr_q;

    upd_kind_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
        upd_valid_i |-> !$isunknown(upd_is_branch_i));

endmodule

/* design/btb.sv */
`timescale 1ns/100ps

module btb (
    input  logic                    clk_i,
    input  logic                    rst_ni,

    // Lookup port, driven by the current fetch PC
    input  bp_pkg::pc_addr_u        rd_pc_i,

    // Allocate / update port from branch resolution
    input  logic                    wr_en_i,
    input  bp_pkg::pc_addr_u        wr_pc_i,
    input  logic                    wr_is_branch_i,
    input  logic                    wr_is_jump_i,
    input  logic                    wr_taken_i,
    input  logic [bp_pkg::XLEN-1:0] wr_target_i,
    input  logic                    wr_hit_i,

    output logic                    hit_o,
    output logic                    is_jump_o,
    output logic [bp_pkg::XLEN-1:0] target_o,
    output logic                    bias_o
);

    localparam int DEPTH = 1 << bp_pkg::INDEX_WIDTH;

    logic [DEPTH-1:0]             valid_q;
    logic [bp_pkg::TAG_WIDTH-1:0] tag_mem    [DEPTH];
    logic [bp_pkg::XLEN-1:0]      target_mem [DEPTH];
    logic                         bias_mem   [DEPTH];
    logic                         jump_mem   [DEPTH];
    logic                         wr_fire;

    // Only control-flow instructions get an entry
    assign wr_fire = wr_en_i && (wr_is_branch_i || wr_is_jump_i);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (wr_fire) begin
            valid_q[wr_pc_i.f.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_fire) begin
            tag_mem[wr_pc_i.f.index]    <= wr_pc_i.f.tag;
            target_mem[wr_pc_i.f.index] <= wr_target_i;
            jump_mem[wr_pc_i.f.index]   <= wr_is_jump_i;
            // Bias is the first outcome seen, kept while the entry keeps hitting
            if (!wr_hit_i) begin
                bias_mem[wr_pc_i.f.index] <= wr_taken_i;
            end
        end
    end

    // Combinational read, same cycle as the PC
    assign hit_o     = valid_q[rd_pc_i.f.index] && (tag_mem[rd_pc_i.f.index] == rd_pc_i.f.tag);
    assign is_jump_o = jump_mem[rd_pc_i.f.index];
    assign target_o  = target_mem[rd_pc_i.f.index];
    assign bias_o    = bias_mem[rd_pc_i.f.index];

    wr_index_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wr_fire |-> !$isunknown(wr_pc_i.f.index));

endmodule

/* design/bp_pkg.sv */
package bp_pkg;

    // Address and data width of the core
    localparam int XLEN = 32;

    // Direct-mapped BTB with 4096 entries
    localparam int INDEX_WIDTH = 12;

    // Instructions are word aligned
    localparam int OFFSET_WIDTH = 2;

    // Upper PC bits kept as the BTB tag
    localparam int TAG_WIDTH = XLEN - INDEX_WIDTH - OFFSET_WIDTH;

    // First fetch address after reset
    localparam logic [XLEN-1:0] RESET_PC = '0;

    // Weakly agree, so a fresh counter follows the BTB bias
    localparam logic [1:0] CTR_WEAK_AGREE = 2'b10;

    // One PC word seen either as a flat address or as BTB lookup fields
    typedef union packed {
        logic [XLEN-1:0] raw;
        struct packed {
            logic [TAG_WIDTH-1:0]    tag;
            logic [INDEX_WIDTH-1:0]  index;
            logic [OFFSET_WIDTH-1:0] offset;
        } f;
    } pc_addr_u;

endpackage
